// ==== wr_bridge_macros.svh ====
`ifndef WR_BRIDGE_MACROS_SVH
`define WR_BRIDGE_MACROS_SVH

// datapath geometry
`define WB_DW_BITS        32            // one PCIe double word
`define WB_DATA_BITS      256           // TLP and AXI beat width
`define WB_BEAT_DWS       8             // DWs per beat
`define WB_STRB_BITS      32            // one strobe bit per byte
`define WB_ADDR_BITS      64
`define WB_ID_BITS        8
`define WB_MAX_BEATS_BITS 8             // 1024 DW plus offset is 129 beats

`define WB_FIFO_DEPTH     16

// fixed AW attributes
`define WB_AXI_SIZE       3'd5          // 32 bytes per beat
`define WB_AXI_CACHE      4'b0011       // bufferable, modifiable
`define WB_AXI_PROT       3'b010        // unprivileged, non-secure, data

`endif

// ==== tlp_pkg.sv ====
`include "wr_bridge_macros.svh"

package tlp_pkg;

    // fmt codes for memory writes
    typedef enum logic [2:0] {
        FMT_3DW_DATA = 3'b010,
        FMT_4DW_DATA = 3'b011
    } tlp_fmt_e;

    // header as DW0..DW3, DW0 in the top bits
    typedef struct packed {
        tlp_fmt_e                fmt;
        logic [4:0]              tlp_type;
        logic [8:0]              dw0_misc_hi;   // tag msbs, tc, attr[2], ln, th, td
        logic                    ep;            // poisoned
        logic [3:0]              dw0_misc_lo;   // attr[1:0], at
        logic [9:0]              length;        // 0 means 1024 DW
        logic [23:0]             dw1_misc;      // requester id, tag
        logic [3:0]              last_be;
        logic [3:0]              first_be;
        logic [`WB_DW_BITS-1:0]  addr_dw2;      // 3DW address lives here
        logic [`WB_DW_BITS-1:0]  addr_dw3;      // low address word of a 4DW header
    } tlp_hdr_t;

    // decoded write request handed to the AXI side
    typedef struct packed {
        logic [`WB_ADDR_BITS-1:0]      addr;      // DW aligned
        logic [2:0]                    dw_offset; // addr[4:2]
        logic [10:0]                   length_dw;
        logic [`WB_MAX_BEATS_BITS-1:0] beats;     // AXI beats after realignment
        logic [3:0]                    first_be;
        logic [3:0]                    last_be;
    } tlp_wr_req_t;

    typedef enum logic [1:0] {
        RX_RECV,
        RX_FLUSH,
        RX_WAIT_DONE
    } rx_state_e;

endpackage

// ==== axi_pkg.sv ====
`include "wr_bridge_macros.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef struct packed {
        logic [`WB_ID_BITS-1:0]   id;
        logic [`WB_ADDR_BITS-1:0] addr;
        logic [7:0]               len;    // beats minus one
        logic [2:0]               size;
        axi_burst_e               burst;
        logic                     lock;
        logic [3:0]               cache;
        logic [2:0]               prot;
    } axi_aw_t;

    typedef struct packed {
        logic [`WB_DATA_BITS-1:0] data;
        logic [`WB_STRB_BITS-1:0] strb;
        logic                     last;
    } axi_w_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SEND,
        WR_FINISH
    } wr_state_e;

endpackage

// ==== data_fifo.sv ====
`timescale 1ns/1ns
`include "wr_bridge_macros.svh"

module data_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  logic [`WB_DATA_BITS-1:0] wr_data,
    input  logic                     rd_en,
    output logic [`WB_DATA_BITS-1:0] rd_data,
    output logic                     full,
    output logic                     empty
);

    localparam int ADDR_BITS = $clog2(`WB_FIFO_DEPTH);

    logic [`WB_DATA_BITS-1:0] mem [`WB_FIFO_DEPTH];
    logic [ADDR_BITS-1:0]     wr_ptr;
    logic [ADDR_BITS-1:0]     rd_ptr;
    logic [ADDR_BITS:0]       count;
    logic                     do_wr;
    logic                     do_rd;

    assign do_wr = wr_en && !full;   // overflow guard
    assign do_rd = rd_en && !empty;

    assign full  = (count == (ADDR_BITS+1)'(`WB_FIFO_DEPTH));
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr];   // valid the cycle after rd_en
        end
    end

endmodule

// ==== tlp_rx_align.sv ====
`timescale 1ns/1ns
`include "wr_bridge_macros.svh"

module tlp_rx_align (
    input  logic                     clk,
    input  logic                     rst_n,
    input  tlp_pkg::tlp_hdr_t        tlp_hdr,
    input  logic [`WB_DATA_BITS-1:0] tlp_data,
    input  logic                     tlp_sop,
    input  logic                     tlp_eop,
    input  logic                     tlp_valid,
    output logic                     tlp_ready,
    input  logic                     fifo_full,
    output logic                     fifo_wr_en,
    output logic [`WB_DATA_BITS-1:0] fifo_wr_data,
    output tlp_pkg::tlp_wr_req_t     wr_req,
    output logic                     start,
    input  logic                     done
);

    tlp_pkg::rx_state_e         state;
    tlp_pkg::rx_state_e         state_nxt;
    logic [`WB_ADDR_BITS-1:0]   hdr_addr;
    logic [10:0]                hdr_len;
    logic [2:0]                 hdr_offset;
    logic [11:0]                hdr_span;
    logic [11:0]                hdr_in_span;
    logic                       hdr_flush;
    logic                       accept;
    logic                       poisoned;
    logic                       cur_flush;
    logic [2:0]                 cur_offset;
    logic                       ready_nxt;
    logic                       start_d1;
    logic                       pending;
    logic                       poison_q;
    logic                       flush_q;
    logic [`WB_DATA_BITS-1:0]   prev_q;
    logic [`WB_DATA_BITS-1:0]   align_hi;
    logic [`WB_DATA_BITS-1:0]   align_lo;
    logic [2*`WB_DATA_BITS-1:0] align_cat;

    // header decode, meaningful on sop beats
    always_comb begin
        if (tlp_hdr.fmt == tlp_pkg::FMT_4DW_DATA) begin
            hdr_addr = {tlp_hdr.addr_dw2, tlp_hdr.addr_dw3[31:2], 2'b00};
        end else begin
            hdr_addr = {32'd0, tlp_hdr.addr_dw2[31:2], 2'b00};
        end
        hdr_len     = {tlp_hdr.length == 10'd0, tlp_hdr.length};
        hdr_offset  = hdr_addr[4:2];
        hdr_span    = {9'd0, hdr_offset} + {1'b0, hdr_len} + 12'd7;
        hdr_in_span = {1'b0, hdr_len} + 12'd7;
        hdr_flush   = (hdr_span[10:3] != hdr_in_span[10:3]);   // one more output beat
    end

    assign accept     = tlp_valid && tlp_ready;
    assign poisoned   = tlp_sop ? tlp_hdr.ep : poison_q;
    assign cur_flush  = tlp_sop ? hdr_flush : flush_q;
    assign cur_offset = (state == tlp_pkg::RX_RECV && tlp_sop) ? hdr_offset
                                                                : wr_req.dw_offset;

    always_comb begin
        state_nxt  = state;
        ready_nxt  = 1'b0;
        fifo_wr_en = 1'b0;
        align_hi   = tlp_data;
        align_lo   = tlp_sop ? '0 : prev_q;
        case (state)
            tlp_pkg::RX_RECV: begin
                ready_nxt  = !fifo_full && !accept;   // bubble after every beat
                fifo_wr_en = accept && !poisoned;
                if (accept && tlp_eop) begin
                    if (!poisoned && cur_flush) begin
                        state_nxt = tlp_pkg::RX_FLUSH;
                    end else begin
                        state_nxt = tlp_pkg::RX_WAIT_DONE;
                    end
                end
            end
            tlp_pkg::RX_FLUSH: begin
                align_hi = '0;   // tail of the last payload beat
                align_lo = prev_q;
                if (!fifo_full) begin
                    fifo_wr_en = 1'b1;
                    state_nxt  = tlp_pkg::RX_WAIT_DONE;
                end
            end
            tlp_pkg::RX_WAIT_DONE: begin
                if (!pending) begin
                    state_nxt = tlp_pkg::RX_RECV;
                end
            end
            default: state_nxt = tlp_pkg::RX_WAIT_DONE;
        endcase
    end

    // shift payload up by dw_offset lanes onto the AXI grid
    assign align_cat    = {align_hi, align_lo} << (cur_offset * `WB_DW_BITS);
    assign fifo_wr_data = align_cat[2*`WB_DATA_BITS-1 -: `WB_DATA_BITS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= tlp_pkg::RX_WAIT_DONE;
            tlp_ready <= 1'b0;
            start_d1  <= 1'b0;
            start     <= 1'b0;
            pending   <= 1'b0;
            poison_q  <= 1'b0;
            flush_q   <= 1'b0;
        end else begin
            state     <= state_nxt;
            tlp_ready <= ready_nxt;
            start_d1  <= accept && tlp_sop && !tlp_hdr.ep;
            start     <= start_d1;   // two cycles after sop
            if (accept && tlp_sop) begin
                poison_q <= tlp_hdr.ep;
                flush_q  <= hdr_flush;
            end
            if (accept && tlp_sop && !tlp_hdr.ep) begin
                pending <= 1'b1;   // held until the engine is done
            end else if (done) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prev_q <= tlp_data;
        end
        if (accept && tlp_sop && !tlp_hdr.ep) begin
            wr_req <= '{addr:      hdr_addr,
                        dw_offset: hdr_offset,
                        length_dw: hdr_len,
                        beats:     hdr_span[3 +: `WB_MAX_BEATS_BITS],
                        first_be:  tlp_hdr.first_be,
                        last_be:   tlp_hdr.last_be};
        end
    end

endmodule

// ==== axi_wr_engine.sv ====
`timescale 1ns/1ns
`include "wr_bridge_macros.svh"

module axi_wr_engine (
    input  logic                     clk,
    input  logic                     rst_n,
    input  tlp_pkg::tlp_wr_req_t     wr_req,
    input  logic                     start,
    output logic                     done,
    output logic                     fifo_rd_en,
    input  logic [`WB_DATA_BITS-1:0] fifo_rd_data,
    input  logic                     fifo_empty,
    output axi_pkg::axi_aw_t         axi_aw,
    output logic                     axi_awvalid,
    input  logic                     axi_awready,
    output axi_pkg::axi_w_t          axi_w,
    output logic                     axi_wvalid,
    input  logic                     axi_wready
);

    axi_pkg::wr_state_e            state;
    logic [1:0]                    be_offset;
    logic                          rd_pending;
    logic                          w_fire;
    logic [`WB_MAX_BEATS_BITS-1:0] beat_cnt;
    logic [10:0]                   first_pos;
    logic [10:0]                   end_pos;
    logic [10:0]                   lane_pos;
    logic [`WB_STRB_BITS-1:0]      beat_strb;
    logic [`WB_DATA_BITS-1:0]      w_data_q;
    logic [`WB_STRB_BITS-1:0]      w_strb_q;
    logic                          w_last_q;

    // byte offset of the first enabled byte
    always_comb begin
        casez (wr_req.first_be)
            4'b???1: be_offset = 2'd0;
            4'b??10: be_offset = 2'd1;
            4'b?100: be_offset = 2'd2;
            4'b1000: be_offset = 2'd3;
            default: be_offset = 2'd0;   // zero-length write
        endcase
    end

    // strobes for the beat about to be loaded, by absolute DW position
    always_comb begin
        first_pos = {8'd0, wr_req.dw_offset};
        end_pos   = first_pos + wr_req.length_dw - 11'd1;
        lane_pos  = '0;
        beat_strb = '0;
        for (int l = 0; l < `WB_BEAT_DWS; l++) begin
            lane_pos = {beat_cnt, 3'd0} + 11'(l);
            if (lane_pos < first_pos || lane_pos > end_pos) begin
                beat_strb[4*l +: 4] = 4'h0;
            end else if (lane_pos == first_pos) begin
                beat_strb[4*l +: 4] = wr_req.first_be;   // also covers length 1
            end else if (lane_pos == end_pos) begin
                beat_strb[4*l +: 4] = wr_req.last_be;
            end else begin
                beat_strb[4*l +: 4] = 4'hf;
            end
        end
    end

    assign w_fire     = axi_wvalid && axi_wready;
    assign fifo_rd_en = (state == axi_pkg::WR_SEND) && !fifo_empty && !rd_pending
                        && !axi_wvalid;
    assign done       = (state == axi_pkg::WR_FINISH) && !axi_awvalid;

    assign axi_w = '{data: w_data_q, strb: w_strb_q, last: w_last_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= axi_pkg::WR_IDLE;
            axi_awvalid <= 1'b0;
            axi_wvalid  <= 1'b0;
            w_last_q    <= 1'b0;
            rd_pending  <= 1'b0;
            beat_cnt    <= '0;
        end else begin
            rd_pending <= fifo_rd_en;
            if (axi_awvalid && axi_awready) begin
                axi_awvalid <= 1'b0;
            end
            case (state)
                axi_pkg::WR_IDLE: begin
                    if (start) begin
                        axi_awvalid <= 1'b1;
                        beat_cnt    <= '0;
                        state       <= axi_pkg::WR_SEND;
                    end
                end
                axi_pkg::WR_SEND: begin
                    if (rd_pending) begin
                        axi_wvalid <= 1'b1;
                        w_last_q   <= (beat_cnt == axi_aw.len);
                    end
                    if (w_fire) begin
                        axi_wvalid <= 1'b0;
                        beat_cnt   <= beat_cnt + 1'b1;
                        if (w_last_q) begin
                            w_last_q <= 1'b0;
                            state    <= axi_pkg::WR_FINISH;
                        end
                    end
                end
                axi_pkg::WR_FINISH: begin
                    if (!axi_awvalid) begin   // AW may still be pending
                        state <= axi_pkg::WR_IDLE;
                    end
                end
                default: state <= axi_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == axi_pkg::WR_IDLE && start) begin
            axi_aw <= '{id:    '0,
                        addr:  wr_req.addr + {62'd0, be_offset},
                        len:   wr_req.beats - 8'd1,
                        size:  `WB_AXI_SIZE,
                        burst: axi_pkg::BURST_INCR,
                        lock:  1'b0,
                        cache: `WB_AXI_CACHE,
                        prot:  `WB_AXI_PROT};
        end
        if (rd_pending) begin
            w_data_q <= fifo_rd_data;
            w_strb_q <= beat_strb;
        end
    end

endmodule

// ==== wr_tlp_axi.sv ====
`timescale 1ns/1ns
`include "wr_bridge_macros.svh"

module wr_tlp_axi (
    input  logic                     clk,
    input  logic                     rst_n,
    // TLP side
    input  tlp_pkg::tlp_hdr_t        tlp_hdr,
    input  logic [`WB_DATA_BITS-1:0] tlp_data,
    input  logic                     tlp_sop,
    input  logic                     tlp_eop,
    input  logic                     tlp_valid,
    output logic                     tlp_ready,
    output logic                     tlp_error,
    // AXI write side
    output axi_pkg::axi_aw_t         axi_aw,
    output logic                     axi_awvalid,
    input  logic                     axi_awready,
    output axi_pkg::axi_w_t          axi_w,
    output logic                     axi_wvalid,
    input  logic                     axi_wready,
    output logic                     axi_bready
);

    logic                     fifo_wr_en;
    logic [`WB_DATA_BITS-1:0] fifo_wr_data;
    logic                     fifo_rd_en;
    logic [`WB_DATA_BITS-1:0] fifo_rd_data;
    logic                     fifo_full;
    logic                     fifo_empty;
    tlp_pkg::tlp_wr_req_t     wr_req;
    logic                     start;
    logic                     done;

    assign tlp_error  = tlp_valid && tlp_hdr.ep;
    assign axi_bready = 1'b1;   // responses are not tracked

    tlp_rx_align u_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .tlp_hdr      (tlp_hdr),
        .tlp_data     (tlp_data),
        .tlp_sop      (tlp_sop),
        .tlp_eop      (tlp_eop),
        .tlp_valid    (tlp_valid),
        .tlp_ready    (tlp_ready),
        .fifo_full    (fifo_full),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data),
        .wr_req       (wr_req),
        .start        (start),
        .done         (done)
    );

    data_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (fifo_wr_en),
        .wr_data (fifo_wr_data),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    axi_wr_engine u_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_req       (wr_req),
        .start        (start),
        .done         (done),
        .fifo_rd_en   (fifo_rd_en),
        .fifo_rd_data (fifo_rd_data),
        .fifo_empty   (fifo_empty),
        .axi_aw       (axi_aw),
        .axi_awvalid  (axi_awvalid),
        .axi_awready  (axi_awready),
        .axi_w        (axi_w),
        .axi_wvalid   (axi_wvalid),
        .axi_wready   (axi_wready)
    );

endmodule

// ==== tb_wr_tlp_axi.sv ====
`timescale 1ns/1ns
`include "wr_bridge_macros.svh"

module tb_wr_tlp_axi;

    localparam int TIMEOUT_CYCLES = 5000;
    localparam int RANDOM_TLPS    = 40;

    logic                     clk         = 1'b0;
    logic                     rst_n;
    tlp_pkg::tlp_hdr_t        tlp_hdr;
    logic [`WB_DATA_BITS-1:0] tlp_data;
    logic                     tlp_sop;
    logic                     tlp_eop;
    logic                     tlp_valid;
    logic                     tlp_ready;
    logic                     tlp_error;
    axi_pkg::axi_aw_t         axi_aw;
    logic                     axi_awvalid;
    logic                     axi_awready = 1'b0;
    axi_pkg::axi_w_t          axi_w;
    logic                     axi_wvalid;
    logic                     axi_wready  = 1'b0;
    logic                     axi_bready;

    integer seed       = 32'h9a30;
    integer stall_seed = 32'h9a30;   // own stream for the ready stalls

    axi_pkg::axi_aw_t exp_aw_q [$];   // one entry per clean TLP
    axi_pkg::axi_w_t  exp_w_q [$];    // every expected W beat, in order

    logic             aw_wait = 1'b0;
    logic             w_wait  = 1'b0;
    axi_pkg::axi_aw_t aw_prev;
    axi_pkg::axi_w_t  w_prev;

    wr_tlp_axi UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .tlp_hdr     (tlp_hdr),
        .tlp_data    (tlp_data),
        .tlp_sop     (tlp_sop),
        .tlp_eop     (tlp_eop),
        .tlp_valid   (tlp_valid),
        .tlp_ready   (tlp_ready),
        .tlp_error   (tlp_error),
        .axi_aw      (axi_aw),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .axi_w       (axi_w),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready),
        .axi_bready  (axi_bready)
    );

    always #2 clk = ~clk;   // 4 ns period

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic compare_values(input string name, input logic [255:0] got,
                                  input logic [255:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h",
                                     name, got, exp));
        end
    endtask

    // random slave stalls, W side held off longer so the FIFO fills
    always @(posedge clk) begin
        logic [31:0] rnd;
        #1;
        rnd         = $random(stall_seed);
        axi_awready = (rnd[1:0] != 2'd0);
        axi_wready  = (rnd[4:2] > 3'd2);
    end

    // AXI monitor, compares every handshake with the model queues
    always @(posedge clk) begin
        axi_pkg::axi_aw_t         exp_aw;
        axi_pkg::axi_w_t          exp_w;
        logic [`WB_DATA_BITS-1:0] mask;
        if (!rst_n) begin
            aw_wait = 1'b0;
            w_wait  = 1'b0;
        end else begin
            if (aw_wait) begin   // stalled last edge, must hold
                compare_values("axi_awvalid held", axi_awvalid, 1'b1);
                compare_values("axi_aw held", axi_aw, aw_prev);
            end
            if (w_wait) begin
                compare_values("axi_wvalid held", axi_wvalid, 1'b1);
                compare_values("axi_w.data held", axi_w.data, w_prev.data);
                compare_values("axi_w.strb/last held", {axi_w.strb, axi_w.last},
                               {w_prev.strb, w_prev.last});
            end
            if (axi_awvalid && axi_awready) begin
                if (exp_aw_q.size() == 0) begin
                    report_failure("AW handshake seen while no write was outstanding");
                end else begin
                    exp_aw = exp_aw_q.pop_front();
                    compare_values("axi_aw.addr", axi_aw.addr, exp_aw.addr);
                    compare_values("axi_aw.len", axi_aw.len, exp_aw.len);
                    compare_values("axi_aw", axi_aw, exp_aw);   // fixed attributes
                end
            end
            if (axi_wvalid && axi_wready) begin
                if (exp_w_q.size() == 0) begin
                    report_failure("W handshake seen while no beat was outstanding");
                end else begin
                    exp_w = exp_w_q.pop_front();
                    for (int b = 0; b < `WB_STRB_BITS; b++) begin
                        mask[8*b +: 8] = {8{exp_w.strb[b]}};
                    end
                    compare_values("axi_w.strb", axi_w.strb, exp_w.strb);
                    compare_values("axi_w.last", axi_w.last, exp_w.last);
                    compare_values("axi_w.data", axi_w.data & mask, exp_w.data & mask);
                end
            end
            aw_wait = axi_awvalid && !axi_awready;
            aw_prev = axi_aw;
            w_wait  = axi_wvalid && !axi_wready;
            w_prev  = axi_w;
        end
    end

    // builds one TLP, queues its expected AXI write and drives its beats
    task automatic send_tlp(input int len, input logic poison, input int force_off);
        tlp_pkg::tlp_hdr_t        hdr;
        axi_pkg::axi_aw_t         aw;
        axi_pkg::axi_w_t          w;
        logic [`WB_DATA_BITS-1:0] beats_in [128];
        logic [63:0]              dw_addr;
        logic [31:0]              rnd;
        logic [3:0]               fbe;
        logic [3:0]               lbe;
        logic [1:0]               byte_off;
        logic                     four_dw;
        logic                     accepted;
        int                       off;
        int                       n_in;
        int                       n_out;
        int                       idx;
        int                       idle;
        int                       cycles;

        rnd     = $random(seed);
        four_dw = rnd[0];
        fbe     = (rnd[7:4] == 4'h0) ? 4'hf : rnd[7:4];
        lbe     = (rnd[11:8] == 4'h0) ? 4'hf : rnd[11:8];
        if (len == 1) begin
            lbe = 4'h0;   // single DW carries no last BE
        end
        dw_addr[63:32] = $random(seed);
        dw_addr[31:0]  = $random(seed);
        dw_addr[1:0]   = 2'b00;
        if (!four_dw) begin
            dw_addr[63:32] = '0;
        end
        if (force_off >= 0) begin
            dw_addr[4:2] = force_off[2:0];
        end
        off   = {29'd0, dw_addr[4:2]};
        n_in  = (len + 7) / 8;
        n_out = (off + len + 7) / 8;
        for (int b = 0; b < n_in; b++) begin
            for (int l = 0; l < `WB_BEAT_DWS; l++) begin
                beats_in[b][32*l +: 32] = $random(seed);   // tail DWs are filler
            end
        end

        hdr          = '0;
        hdr.fmt      = four_dw ? tlp_pkg::FMT_4DW_DATA : tlp_pkg::FMT_3DW_DATA;
        hdr.ep       = poison;
        hdr.length   = len[9:0];   // 1024 wraps to 0
        hdr.first_be = fbe;
        hdr.last_be  = lbe;
        if (four_dw) begin
            hdr.addr_dw2 = dw_addr[63:32];
            hdr.addr_dw3 = dw_addr[31:0];
        end else begin
            hdr.addr_dw2 = dw_addr[31:0];
            hdr.addr_dw3 = $random(seed);   // not part of a 3DW header
        end

        if (!poison) begin
            byte_off = fbe[0] ? 2'd0 : fbe[1] ? 2'd1 : fbe[2] ? 2'd2 : 2'd3;
            idx      = n_out - 1;
            aw       = '0;
            aw.addr  = dw_addr + {62'd0, byte_off};
            aw.len   = idx[7:0];
            aw.size  = 3'd5;
            aw.burst = axi_pkg::BURST_INCR;
            aw.cache = 4'b0011;
            aw.prot  = 3'b010;
            exp_aw_q.push_back(aw);
            for (int k = 0; k < n_out; k++) begin
                w = '0;
                for (int l = 0; l < `WB_BEAT_DWS; l++) begin
                    idx = 8 * k + l - off;   // payload DW index of this lane
                    if (idx >= 0 && idx < len) begin
                        w.data[32*l +: 32] = beats_in[idx / 8][32 * (idx % 8) +: 32];
                        if (idx == 0) begin
                            w.strb[4*l +: 4] = fbe;
                        end else if (idx == len - 1) begin
                            w.strb[4*l +: 4] = lbe;
                        end else begin
                            w.strb[4*l +: 4] = 4'hf;
                        end
                    end
                end
                w.last = (k == n_out - 1);
                exp_w_q.push_back(w);
            end
        end

        for (int b = 0; b < n_in; b++) begin
            rnd       = $random(seed);
            idle      = (rnd[2:0] < 3'd3) ? {30'd0, rnd[4:3]} : 0;
            tlp_valid = 1'b0;
            repeat (idle) begin
                @(posedge clk);
                #1;
            end
            tlp_hdr   = hdr;
            tlp_data  = beats_in[b];
            tlp_sop   = (b == 0);
            tlp_eop   = (b == n_in - 1);
            tlp_valid = 1'b1;
            cycles    = 0;
            accepted  = 1'b0;
            while (!accepted) begin
                @(posedge clk);
                compare_values("tlp_error", tlp_error, poison);
                accepted = tlp_ready;
                cycles++;
                if (!accepted && cycles > TIMEOUT_CYCLES) begin
                    report_failure("timed out waiting for tlp_ready to accept a beat");
                end
            end
            #1;
        end
        tlp_valid = 1'b0;
        tlp_sop   = 1'b0;
        tlp_eop   = 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_aw_q.size() != 0 || exp_w_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_failure("timed out waiting for the last AXI write to finish");
            end
        end
        repeat (20) @(posedge clk);   // quiet window for stray AW or W beats
    endtask

    initial begin
        logic [31:0] rnd;
        int          len;
        rst_n     = 1'b0;
        tlp_hdr   = '0;
        tlp_data  = '0;
        tlp_sop   = 1'b0;
        tlp_eop   = 1'b0;
        tlp_valid = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        compare_values("tlp_ready", tlp_ready, 1'b0);
        compare_values("axi_awvalid", axi_awvalid, 1'b0);
        compare_values("axi_wvalid", axi_wvalid, 1'b0);
        compare_values("axi_w.last", axi_w.last, 1'b0);
        compare_values("axi_bready", axi_bready, 1'b1);
        #1;

        send_tlp(1, 1'b0, 5);        // single DW inside a beat
        send_tlp(1024, 1'b0, 7);     // 129 beats, fills the FIFO
        send_tlp(12, 1'b1, -1);
        send_tlp(9, 1'b0, 0);
        send_tlp(1024, 1'b1, 3);     // long poisoned TLP
        send_tlp(1, 1'b0, 0);
        for (int n = 0; n < RANDOM_TLPS; n++) begin
            rnd = $random(seed);
            len = {26'd0, rnd[5:0]} + 1;
            send_tlp(len, rnd[10:8] == 3'd0, -1);
        end

        wait_drained();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
tlp_pkg.sv
axi_pkg.sv
data_fifo.sv
tlp_rx_align.sv
axi_wr_engine.sv
wr_tlp_axi.sv
tb_wr_tlp_axi.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_wr_tlp_axi
RTL_TOP   := wr_tlp_axi
FILELIST  := filelist.f
VFLAGS    := --timing -Wall -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation of $(RTL_TOP) failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
